//--- common/net_pkg.sv
// network package
// remote request format leaving the tile through the network port,
// the load description that rides along with it and the atomic types

package net_pkg;

  // atomic operation carried by a remote amo request
  typedef enum logic [2:0] {
    amo_swap = 3'd0,
    amo_add  = 3'd1,
    amo_and  = 3'd2,
    amo_or   = 3'd3,
    amo_xor  = 3'd4
  } amo_type_e;

  // describes how the returning word of a remote load is to be used
  // op_width holds the same encoding as core_pkg::op_width_e
  typedef struct packed {
    logic       float_wb;
    logic       icache_fetch;
    logic       is_unsigned;
    logic [1:0] op_width;
    logic [1:0] part_sel;
  } load_info_s;

  // one request toward the network
  typedef struct packed {
    logic        write_not_read;
    logic        is_amo;
    amo_type_e   amo_type;
    // byte enables for stores
    logic [3:0]  mask;
    load_info_s  load_info;
    // destination register of the load result
    logic [4:0]  reg_id;
    logic [31:0] data;
    logic [31:0] addr;
  } remote_req_s;

endpackage

//--- common/core_pkg.sv
// core package
// execute-stage decode fields seen by the memory-access block:
// memory operation, access width and the register index width

package core_pkg;

  // register file index width
  localparam int reg_addr_width_c = 5;

  // memory operation of the instruction in execute
  typedef enum logic [2:0] {
    mem_none  = 3'd0,
    mem_load  = 3'd1,
    mem_store = 3'd2,
    mem_lr    = 3'd3,
    mem_lr_aq = 3'd4,
    mem_amo   = 3'd5
  } mem_op_e;

  // access width, same encoding as load_info_s.op_width
  typedef enum logic [1:0] {
    width_byte = 2'd0,
    width_half = 2'd1,
    width_word = 2'd2
  } op_width_e;

  // decode of the memory instruction in execute
  typedef struct packed {
    mem_op_e            mem_op;
    op_width_e          op_width;
    // zero-extend byte and half loads
    logic               is_unsigned;
    // load writes the float register file
    logic               write_frd;
    net_pkg::amo_type_e amo_type;
  } decode_s;

endpackage

//--- common/dmem_if.sv
// local data memory request
// one strobe per access from the load store unit to the data memory

interface dmem_if #(
  parameter int dmem_size_p = 1024
);

  localparam int addr_width_lp = $clog2(dmem_size_p);

  logic                     v;
  logic                     w;
  // word index, not byte address
  logic [addr_width_lp-1:0] addr;
  logic [31:0]              data;
  logic [3:0]               mask;

  modport master (
    output v, w, addr, data, mask
  );

  modport slave (
    input v, w, addr, data, mask
  );

endinterface

//--- lsu/lsu.sv
// load store unit
// generates the effective address, places store data and byte mask,
// routes the access to local data memory or to the network, and forms
// the instruction-cache miss fetch

module lsu #(
  parameter int pc_width_p  = 22,
  parameter int dmem_size_p = 1024
) (
  input  core_pkg::decode_s                          exe_decode_i,
  input  logic [31:0]                                exe_rs1_i,
  input  logic [31:0]                                exe_rs2_i,
  input  logic [core_pkg::reg_addr_width_c-1:0]      exe_rd_i,
  input  logic [11:0]                                mem_offset_i,
  // word address of the next instruction
  input  logic [pc_width_p-1:0]                      pc_plus4_i,
  input  logic                                       icache_miss_i,

  dmem_if.master                                     dmem,

  output net_pkg::remote_req_s                       remote_req_o,
  output logic                                       remote_req_v_o,
  output logic                                       reserve_o,
  output logic [1:0]                                 part_sel_o
);

  import core_pkg::*;
  import net_pkg::*;

  localparam int dmem_addr_width_lp  = $clog2(dmem_size_p);
  localparam int local_addr_width_lp = dmem_addr_width_lp + 2;

  logic [31:0]           mem_addr;
  logic [31:0]           miss_addr;
  logic [pc_width_p-1:0] miss_pc;
  logic [31:0]           store_data;
  logic [3:0]            store_mask;
  logic                  is_local;
  logic                  is_load;
  logic                  is_store;
  logic                  is_amo;
  logic                  is_lr;
  logic                  is_lr_aq;
  load_info_s            load_info;

  assign is_load  = (exe_decode_i.mem_op == mem_load);
  assign is_store = (exe_decode_i.mem_op == mem_store);
  assign is_amo   = (exe_decode_i.mem_op == mem_amo);
  assign is_lr    = (exe_decode_i.mem_op == mem_lr);
  assign is_lr_aq = (exe_decode_i.mem_op == mem_lr_aq);

  assign mem_addr = exe_rs1_i + {{20{mem_offset_i[11]}}, mem_offset_i};

  // miss fetch goes to the top half of the address map, byte addressed
  assign miss_pc   = pc_plus4_i - 1'b1;
  assign miss_addr = {1'b1, {(32-pc_width_p-3){1'b0}}, miss_pc, 2'b00};

  // local data memory occupies the lowest 4*dmem_size_p bytes
  assign is_local = (mem_addr[31:local_addr_width_lp] == '0);

  // byte and half stores replicate into every lane
  always_comb begin
    case (exe_decode_i.op_width)
      width_byte: begin
        store_data = {4{exe_rs2_i[7:0]}};
        store_mask = 4'b0001 << mem_addr[1:0];
      end
      width_half: begin
        store_data = {2{exe_rs2_i[15:0]}};
        store_mask = mem_addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        // word access, amo included
        store_data = exe_rs2_i;
        store_mask = 4'b1111;
      end
    endcase
  end

  // local access
  assign dmem.v    = is_local & (is_load | is_store | is_lr | is_lr_aq);
  assign dmem.w    = is_store;
  assign dmem.addr = mem_addr[2 +: dmem_addr_width_lp];
  assign dmem.data = store_data;
  assign dmem.mask = store_mask;

  // lane of a local load, for the aligner
  assign part_sel_o = mem_addr[1:0];

  // only a plain lr holds a reservation
  assign reserve_o = is_lr & is_local;

  // miss fetch is always a full word read
  always_comb begin
    if (icache_miss_i) begin
      load_info.float_wb     = 1'b0;
      load_info.icache_fetch = 1'b1;
      load_info.is_unsigned  = 1'b0;
      load_info.op_width     = width_word;
      load_info.part_sel     = 2'b00;
    end else begin
      load_info.float_wb     = exe_decode_i.write_frd;
      load_info.icache_fetch = 1'b0;
      load_info.is_unsigned  = exe_decode_i.is_unsigned;
      load_info.op_width     = exe_decode_i.op_width;
      load_info.part_sel     = mem_addr[1:0];
    end
  end

  always_comb begin
    remote_req_o.write_not_read = is_store & ~icache_miss_i;
    remote_req_o.is_amo         = is_amo & ~icache_miss_i;
    remote_req_o.amo_type       = exe_decode_i.amo_type;
    remote_req_o.mask           = store_mask;
    remote_req_o.load_info      = load_info;
    remote_req_o.reg_id         = exe_rd_i;
    remote_req_o.data           = store_data;
    remote_req_o.addr           = icache_miss_i ? miss_addr : mem_addr;
  end

  // remote lr and local amo are not sent anywhere
  assign remote_req_v_o = icache_miss_i | ((is_load | is_store | is_amo) & ~is_local);

endmodule

//--- lsu/load_align.sv
// load aligner
// captures width, sign and lane of a local read at the request and
// extracts and extends the byte or halfword from the returning word

module load_align (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                load_v_i,
  input  core_pkg::op_width_e op_width_i,
  input  logic                is_unsigned_i,
  input  logic [1:0]          part_sel_i,
  input  logic [31:0]         rdata_i,
  output logic [31:0]         load_data_o,
  output logic                load_data_v_o
);

  import core_pkg::*;

  logic       load_v_q;
  op_width_e  op_width_q;
  logic       is_unsigned_q;
  logic [1:0] part_sel_q;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      load_v_q <= 1'b0;
    end else begin
      load_v_q <= load_v_i;
    end
  end

  // request info for the read in flight
  always_ff @(posedge clk_i) begin
    if (load_v_i) begin
      op_width_q    <= op_width_i;
      is_unsigned_q <= is_unsigned_i;
      part_sel_q    <= part_sel_i;
    end
  end

  assign byte_sel = rdata_i[8*part_sel_q +: 8];
  assign half_sel = part_sel_q[1] ? rdata_i[31:16] : rdata_i[15:0];

  always_comb begin
    case (op_width_q)
      width_byte: load_data_o = {{24{byte_sel[7] & ~is_unsigned_q}}, byte_sel};
      width_half: load_data_o = {{16{half_sel[15] & ~is_unsigned_q}}, half_sel};
      default:    load_data_o = rdata_i;
    endcase
  end

  assign load_data_v_o = load_v_q;

endmodule

//--- lsu/dmem.sv
// local data memory
// word array with per-byte write enables and a registered read port,
// plus one load-reserved reservation on a single word

module dmem #(
  parameter int dmem_size_p = 1024
) (
  input  logic        clk_i,
  input  logic        reset_i,
  dmem_if.slave       req,
  input  logic        reserve_i,
  output logic [31:0] rdata_o,
  output logic        reserve_valid_o
);

  localparam int dmem_addr_width_lp = $clog2(dmem_size_p);

  logic [31:0]                   mem [dmem_size_p];
  logic [31:0]                   rdata_q;
  logic                          reserve_valid_q;
  logic [dmem_addr_width_lp-1:0] reserve_addr_q;
  logic                          store_hits_reserve;

  // writes land at the edge after the strobe
  always_ff @(posedge clk_i) begin
    if (req.v & req.w) begin
      for (int i = 0; i < 4; i++) begin
        if (req.mask[i]) begin
          mem[req.addr][8*i +: 8] <= req.data[8*i +: 8];
        end
      end
    end
  end

  // read word is held until the next read
  always_ff @(posedge clk_i) begin
    if (req.v & ~req.w) begin
      rdata_q <= mem[req.addr];
    end
  end

  assign rdata_o = rdata_q;

  // any byte written to the reserved word breaks the reservation
  assign store_hits_reserve = req.v & req.w & (|req.mask) & (req.addr == reserve_addr_q);

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      reserve_valid_q <= 1'b0;
    end else if (req.v & reserve_i) begin
      reserve_valid_q <= 1'b1;
    end else if (store_hits_reserve) begin
      reserve_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.v & reserve_i) begin
      reserve_addr_q <= req.addr;
    end
  end

  assign reserve_valid_o = reserve_valid_q;

endmodule

//--- logic/lsu_top.sv
// memory-access block top
// load store unit feeding the local data memory and the load aligner;
// remote requests leave straight through the ports

module lsu_top #(
  parameter int pc_width_p  = 22,
  parameter int dmem_size_p = 1024
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  // execute stage
  input  core_pkg::decode_s                     exe_decode_i,
  input  logic [31:0]                           exe_rs1_i,
  input  logic [31:0]                           exe_rs2_i,
  input  logic [core_pkg::reg_addr_width_c-1:0] exe_rd_i,
  input  logic [11:0]                           mem_offset_i,
  input  logic [pc_width_p-1:0]                 pc_plus4_i,
  input  logic                                  icache_miss_i,

  // network
  output net_pkg::remote_req_s                  remote_req_o,
  output logic                                  remote_req_v_o,

  // local load result
  output logic [31:0]                           load_data_o,
  output logic                                  load_data_v_o,

  output logic                                  reserve_valid_o
);

  logic        reserve;
  logic [1:0]  part_sel;
  logic [31:0] rdata;

  dmem_if #(.dmem_size_p(dmem_size_p)) dmem_bus ();

  lsu #(
    .pc_width_p  (pc_width_p),
    .dmem_size_p (dmem_size_p)
  ) u_lsu (
    .exe_decode_i   (exe_decode_i),
    .exe_rs1_i      (exe_rs1_i),
    .exe_rs2_i      (exe_rs2_i),
    .exe_rd_i       (exe_rd_i),
    .mem_offset_i   (mem_offset_i),
    .pc_plus4_i     (pc_plus4_i),
    .icache_miss_i  (icache_miss_i),
    .dmem           (dmem_bus.master),
    .remote_req_o   (remote_req_o),
    .remote_req_v_o (remote_req_v_o),
    .reserve_o      (reserve),
    .part_sel_o     (part_sel)
  );

  dmem #(.dmem_size_p(dmem_size_p)) u_dmem (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req             (dmem_bus.slave),
    .reserve_i       (reserve),
    .rdata_o         (rdata),
    .reserve_valid_o (reserve_valid_o)
  );

  // every local read, lr included, returns through the aligner
  load_align u_load_align (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .load_v_i      (dmem_bus.v & ~dmem_bus.w),
    .op_width_i    (exe_decode_i.op_width),
    .is_unsigned_i (exe_decode_i.is_unsigned),
    .part_sel_i    (part_sel),
    .rdata_i       (rdata),
    .load_data_o   (load_data_o),
    .load_data_v_o (load_data_v_o)
  );

endmodule

//--- tests/lsu_ref.svh
// testbench reference model
// expected address, routing, store lanes, remote request and load
// alignment, derived from the block's address and lane rules

`ifndef LSU_REF_SVH
`define LSU_REF_SVH

function automatic logic [31:0] eff_addr(input logic [31:0] rs1, input logic [11:0] off);
  return rs1 + {{20{off[11]}}, off};
endfunction

// local memory covers the lowest 4*dmem_size_c bytes
function automatic logic addr_is_local(input logic [31:0] addr);
  return addr < 32'(4 * dmem_size_c);
endfunction

function automatic logic [31:0] lane_data(input op_width_e width, input logic [31:0] rs2);
  case (width)
    width_byte: return {4{rs2[7:0]}};
    width_half: return {2{rs2[15:0]}};
    default:    return rs2;
  endcase
endfunction

function automatic logic [3:0] lane_mask(input op_width_e width, input logic [1:0] lane);
  case (width)
    width_byte: return 4'b0001 << lane;
    width_half: return lane[1] ? 4'b1100 : 4'b0011;
    default:    return 4'b1111;
  endcase
endfunction

function automatic remote_req_s expect_remote(input decode_s dec, input logic [31:0] rs1,
    input logic [31:0] rs2, input logic [4:0] rd, input logic [11:0] off,
    input logic [pc_width_c-1:0] pc4, input logic miss);
  remote_req_s           req;
  logic [31:0]           addr;
  logic [pc_width_c-1:0] miss_pc;
  addr               = eff_addr(rs1, off);
  miss_pc            = pc4 - 1;
  req.write_not_read = (dec.mem_op == mem_store) && !miss;
  req.is_amo         = (dec.mem_op == mem_amo) && !miss;
  req.amo_type       = dec.amo_type;
  req.mask           = lane_mask(dec.op_width, addr[1:0]);
  req.data           = lane_data(dec.op_width, rs2);
  req.reg_id         = rd;
  // miss fetch is a word read in the top half of the map
  if (miss) begin
    req.load_info = {1'b0, 1'b1, 1'b0, 2'(width_word), 2'b00};
    req.addr      = 32'h8000_0000 | (32'(miss_pc) << 2);
  end else begin
    req.load_info = {dec.write_frd, 1'b0, dec.is_unsigned, 2'(dec.op_width), addr[1:0]};
    req.addr      = addr;
  end
  return req;
endfunction

function automatic logic [31:0] align_load(input logic [31:0] word, input op_width_e width,
                                           input logic uns, input logic [1:0] lane);
  logic [7:0]  b;
  logic [15:0] h;
  b = 8'(word >> (8 * lane));
  h = lane[1] ? word[31:16] : word[15:0];
  case (width)
    width_byte: return uns ? {24'h0, b} : {{24{b[7]}}, b};
    width_half: return uns ? {16'h0, h} : {{16{h[15]}}, h};
    default:    return word;
  endcase
endfunction

`endif

//--- tests/lsu_tb.sv
// testbench for the memory-access block
// random and directed local and remote traffic, checked every cycle
// against a byte model of the data memory and a shadow reservation

module lsu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import core_pkg::*;
  import net_pkg::*;

  localparam int          pc_width_c     = 22;
  localparam int          dmem_size_c    = 1024;
  localparam int unsigned seed_c         = 32'h877d_8833;
  localparam int          store_load_c   = 300;
  localparam int          align_rounds_c = 12;
  localparam int          mixed_c        = 240;
  localparam int          stim_cycles_c  = dmem_size_c + store_load_c + 16 * align_rounds_c
                                           + mixed_c + 40;
  localparam int          timeout_ns_c   = stim_cycles_c * 20 + 1000;

  logic                  clk_i;
  logic                  reset_i;
  decode_s               exe_decode_i;
  logic [31:0]           exe_rs1_i;
  logic [31:0]           exe_rs2_i;
  logic [4:0]            exe_rd_i;
  logic [11:0]           mem_offset_i;
  logic [pc_width_c-1:0] pc_plus4_i;
  logic                  icache_miss_i;
  remote_req_s           remote_req_o;
  logic                  remote_req_v_o;
  logic [31:0]           load_data_o;
  logic                  load_data_v_o;
  logic                  reserve_valid_o;

  // byte model of the local memory
  logic [7:0]  mem_model [4*dmem_size_c];
  logic        shadow_valid;
  int unsigned shadow_idx;
  int          check_count = 0;
  int          error_count = 0;

  `include "lsu_ref.svh"

  lsu_top #(.pc_width_p(pc_width_c), .dmem_size_p(dmem_size_c)) UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] pick_local_addr();
    return 32'($urandom_range(4 * dmem_size_c - 1, 0));
  endfunction

  // anything at or above the local range
  function automatic logic [31:0] pick_remote_addr();
    return $urandom | 32'(4 * dmem_size_c);
  endfunction

  function automatic logic [31:0] model_read(input int unsigned widx);
    return {mem_model[4*widx+3], mem_model[4*widx+2], mem_model[4*widx+1], mem_model[4*widx]};
  endfunction

  task automatic model_write(input int unsigned widx, input logic [3:0] mask,
                             input logic [31:0] data);
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        mem_model[4*widx+i] = data[8*i +: 8];
      end
    end
  endtask

  // address is reached through a random signed offset
  task automatic drive_access(input mem_op_e op, input op_width_e width, input logic uns,
                              input logic [31:0] addr, input logic [31:0] data,
                              input logic miss);
    logic [11:0] off;
    off = 12'($urandom);
    @(negedge clk_i);
    exe_decode_i.mem_op      = op;
    exe_decode_i.op_width    = width;
    exe_decode_i.is_unsigned = uns;
    exe_decode_i.write_frd   = 1'($urandom);
    exe_decode_i.amo_type    = amo_type_e'($urandom_range(4, 0));
    exe_rs1_i                = addr - {{20{off[11]}}, off};
    exe_rs2_i                = data;
    exe_rd_i                 = 5'($urandom);
    mem_offset_i             = off;
    pc_plus4_i               = pc_width_c'($urandom);
    icache_miss_i            = miss;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      drive_access(mem_none, width_word, 1'b0, 32'h0, 32'h0, 1'b0);
    end
  endtask

  task automatic compare_value(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // inputs still hold the cycle that the last edge sampled
  task automatic score_cycle();
    logic [31:0] addr;
    logic        is_local;
    logic        local_rd;
    logic        local_wr;
    logic        exp_v;
    int unsigned widx;
    mem_op_e     op;
    op       = exe_decode_i.mem_op;
    addr     = eff_addr(exe_rs1_i, mem_offset_i);
    is_local = addr_is_local(addr);
    widx     = addr[31:2];
    local_rd = is_local && (op == mem_load || op == mem_lr || op == mem_lr_aq);
    local_wr = is_local && (op == mem_store);
    exp_v    = icache_miss_i || (!is_local && (op == mem_load || op == mem_store ||
                                               op == mem_amo));
    compare_value("remote_req_v_o", remote_req_v_o, exp_v);
    if (exp_v) begin
      compare_value("remote_req_o", remote_req_o, expect_remote(exe_decode_i, exe_rs1_i,
                    exe_rs2_i, exe_rd_i, mem_offset_i, pc_plus4_i, icache_miss_i));
    end
    if (!reset_i) begin
      shadow_valid = 1'b0;
      compare_value("load_data_v_o", load_data_v_o, 1'b0);
      compare_value("reserve_valid_o", reserve_valid_o, 1'b0);
    end else begin
      compare_value("load_data_v_o", load_data_v_o, local_rd);
      if (local_rd) begin
        compare_value("load_data_o", load_data_o, align_load(model_read(widx),
                      exe_decode_i.op_width, exe_decode_i.is_unsigned, addr[1:0]));
      end
      if (local_wr) begin
        model_write(widx, lane_mask(exe_decode_i.op_width, addr[1:0]),
                    lane_data(exe_decode_i.op_width, exe_rs2_i));
      end
      // lr takes the reservation and a store to its word drops it
      if (is_local && op == mem_lr) begin
        shadow_valid = 1'b1;
        shadow_idx   = widx;
      end else if (local_wr && widx == shadow_idx) begin
        shadow_valid = 1'b0;
      end
      compare_value("reserve_valid_o", reserve_valid_o, shadow_valid);
    end
  endtask

  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      score_cycle();
    end
  end

  initial begin
    #(timeout_ns_c);
    $display("timeout: stimulus did not finish within %0d ns", timeout_ns_c);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] last_store;
    void'($urandom(seed_c));
    reset_i       = 1'b0;
    exe_decode_i  = '0;
    exe_rs1_i     = '0;
    exe_rs2_i     = '0;
    exe_rd_i      = '0;
    mem_offset_i  = '0;
    pc_plus4_i    = '0;
    icache_miss_i = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b1;
    // every word gets a known value before anything reads it
    for (int i = 0; i < dmem_size_c; i++) begin
      drive_access(mem_store, width_word, 1'b0, 32'(4 * i), $urandom, 1'b0);
    end
    for (int i = 0; i < store_load_c; i++) begin
      if (i % 2 == 0) begin
        last_store = pick_local_addr();
        drive_access(mem_store, op_width_e'($urandom_range(2, 0)), 1'b0, last_store,
                     $urandom, 1'b0);
      end else begin
        a = ($urandom_range(1, 0) == 1) ? last_store : pick_local_addr();
        drive_access(mem_load, width_word, 1'b0, a, 32'h0, 1'b0);
      end
    end
    // back-to-back loads over every lane, both widths and both extensions
    for (int r = 0; r < align_rounds_c; r++) begin
      a = pick_local_addr() & ~32'h3;
      for (int k = 0; k < 16; k++) begin
        drive_access(mem_load, k[3] ? width_half : width_byte, k[2], a + 32'(k[1:0]),
                     32'h0, 1'b0);
      end
    end
    // mostly remote traffic with an icache miss every fourth cycle
    for (int i = 0; i < mixed_c; i++) begin
      a = ($urandom_range(3, 0) == 0) ? pick_local_addr() : pick_remote_addr();
      drive_access(mem_op_e'($urandom_range(5, 0)), op_width_e'($urandom_range(2, 0)),
                   1'($urandom), a, $urandom, i % 4 == 0);
    end
    // reservation survives a store elsewhere and breaks on a store to its word
    a = pick_local_addr() & ~32'h3;
    b = (a + 32'(4 * $urandom_range(dmem_size_c - 1, 1))) % 32'(4 * dmem_size_c);
    drive_access(mem_lr, width_word, 1'b0, a, 32'h0, 1'b0);
    drive_access(mem_store, width_word, 1'b0, b, $urandom, 1'b0);
    idle_cycles(2);
    drive_access(mem_store, width_byte, 1'b0, a + 32'd3, $urandom, 1'b0);
    drive_access(mem_lr, width_word, 1'b0, pick_remote_addr(), 32'h0, 1'b0);
    idle_cycles(2);
    // reset drops a live reservation
    drive_access(mem_lr, width_word, 1'b0, b, 32'h0, 1'b0);
    idle_cycles(1);
    reset_i = 1'b0;
    idle_cycles(3);
    reset_i = 1'b1;
    idle_cycles(4);
    // last driven cycle is scored before the summary
    @(negedge clk_i);
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+tests
common/net_pkg.sv
common/core_pkg.sv
common/dmem_if.sv
lsu/lsu.sv
lsu/load_align.sv
lsu/dmem.sv
logic/lsu_top.sv
tests/lsu_tb.sv

//--- Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := lsu_tb
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log
PASS  := TEST OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run the simulation, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
